/* all.f */
src/pma_pkg.sv
src/pma_apb_regs.sv
src/pma_region_match.sv
src/pma_access_classify.sv
src/pma_fault_count.sv
src/pma_monitor_top.sv
tb/pma_monitor_asserts.sv
tb/pma_monitor_tb.sv

/* src/pma_access_classify.sv */
/*
  Acceptance strobe, access kind and alignment of a bus transaction
*/
`timescale 1ns/1ns
`default_nettype none

module pma_access_classify (
  input  logic        trans_valid_i,
  input  logic        trans_ready_i,
  input  logic [1:0]  trans_addr_i,
  input  logic [1:0]  trans_size_i,
  input  logic        trans_write_i,
  input  logic        trans_fetch_i,
  output logic        accept_o,
  output logic [1:0]  kind_o,
  output logic        misaligned_o
);

  assign accept_o = trans_valid_i & trans_ready_i;

  // Fetch takes priority over the write flag
  always_comb begin
    if (trans_fetch_i) begin
      kind_o = pma_pkg::KIND_EXEC;
    end else if (trans_write_i) begin
      kind_o = pma_pkg::KIND_STORE;
    end else begin
      kind_o = pma_pkg::KIND_LOAD;
    end
  end

  always_comb begin
    case (trans_size_i)
      pma_pkg::SIZE_BYTE: misaligned_o = 1'b0;
      pma_pkg::SIZE_HALF: misaligned_o = trans_addr_i[0];
      pma_pkg::SIZE_WORD: misaligned_o = (trans_addr_i != 2'b00);
      // Undefined size code treated as a word
      default:            misaligned_o = (trans_addr_i != 2'b00);
    endcase
  end

endmodule

`default_nettype wire

/* src/pma_apb_regs.sv */
/*
  APB slave for the PMA monitor: address decode, region write strobes,
  counter clear and read mux, one wait state and the error response
*/
`timescale 1ns/1ns
`default_nettype none

module pma_apb_regs (
  input  logic                                 clk_ungated,
  input  logic                                 rst_n,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [pma_pkg::APB_ADDR_W-1:0]       paddr_i,
  input  logic [31:0]                          pwdata_i,
  output logic [31:0]                          prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o,
  output logic [pma_pkg::PMA_NUM_REGIONS-1:0]  region_we_o,
  output logic [pma_pkg::REGION_IDX_W-1:0]     region_idx_o,
  output logic [1:0]                           region_sel_o,
  output logic [31:0]                          wdata_o,
  output logic                                 cnt_clear_o,
  input  logic [pma_pkg::CNT_W-1:0]            cnt_rdata_i,
  output logic [pma_pkg::CNT_IDX_W-1:0]        cnt_idx_o,
  input  logic [31:0]                          region_rdata_i
);

  localparam int STRIDE_SH = $clog2(pma_pkg::REGION_STRIDE);

  logic                             wait_q;
  logic                             region_hit;
  logic                             cnt_hit;
  logic [pma_pkg::APB_ADDR_W-1:0]   cnt_offs;

  // First access cycle is the wait state, pready follows in the second
  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= psel_i & penable_i & ~wait_q;
    end
  end

  assign pready_o = psel_i & penable_i & wait_q;

  // Word aligned base, mask or attr inside the region block
  assign region_hit = (paddr_i < pma_pkg::PMA_NUM_REGIONS * pma_pkg::REGION_STRIDE) &&
                      (paddr_i[3:2] <= pma_pkg::SEL_ATTR) && (paddr_i[1:0] == 2'b00);

  assign cnt_offs = paddr_i - pma_pkg::COUNTER_BASE;
  assign cnt_hit  = (paddr_i >= pma_pkg::COUNTER_BASE) &&
                    (cnt_offs < 4 * pma_pkg::PMA_NUM_COUNTERS) && (paddr_i[1:0] == 2'b00);

  assign region_idx_o = paddr_i[STRIDE_SH +: pma_pkg::REGION_IDX_W];
  assign region_sel_o = paddr_i[3:2];
  assign cnt_idx_o    = cnt_offs[2 +: pma_pkg::CNT_IDX_W];
  assign wdata_o      = pwdata_i;

  // Writes take effect on the pready cycle
  always_comb begin
    region_we_o = '0;
    if (pready_o && pwrite_i && region_hit) begin
      region_we_o[region_idx_o] = 1'b1;
    end
  end

  // Any counter address clears every counter
  assign cnt_clear_o = pready_o & pwrite_i & cnt_hit;

  always_comb begin
    prdata_o = '0;
    if (pready_o && !pwrite_i) begin
      if (region_hit) begin
        prdata_o = region_rdata_i;
      end else if (cnt_hit) begin
        prdata_o = {{(32 - pma_pkg::CNT_W){1'b0}}, cnt_rdata_i};
      end
    end
  end

  assign pslverr_o = pready_o & ~(region_hit | cnt_hit);

endmodule

`default_nettype wire

/* src/pma_fault_count.sv */
/*
  Fault decision with registered result and valid pulse,
  saturating event counters with clear and indexed readback
*/
`timescale 1ns/1ns
`default_nettype none

module pma_fault_count (
  input  logic                                 clk_ungated,
  input  logic                                 rst_n,
  input  logic                                 accept_i,
  input  logic [1:0]                           kind_i,
  input  logic                                 misaligned_i,
  input  logic                                 have_match_i,
  input  logic [pma_pkg::REGION_IDX_W-1:0]     match_idx_i,
  input  logic                                 match_multi_i,
  input  pma_pkg::pma_attr_u                   match_attr_i,
  input  logic                                 cnt_clear_i,
  input  logic [pma_pkg::CNT_IDX_W-1:0]        cnt_idx_i,
  output logic [pma_pkg::CNT_W-1:0]            cnt_rdata_o,
  output logic                                 fault_valid_o,
  output logic                                 fault_o,
  output logic [pma_pkg::REGION_IDX_W-1:0]     fault_region_o
);

  logic                                  fault;
  logic                                  is_exec;
  logic [pma_pkg::PMA_NUM_COUNTERS-1:0]  inc;
  logic [pma_pkg::CNT_W-1:0]             cnt_q [pma_pkg::PMA_NUM_COUNTERS];

  assign is_exec = (kind_i == pma_pkg::KIND_EXEC);

  // io regions take neither misaligned accesses nor fetches
  assign fault = !have_match_i ||
                 !match_attr_i.fields.allow ||
                 (misaligned_i && !match_attr_i.fields.main) ||
                 (is_exec && !match_attr_i.fields.main);

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      fault_valid_o  <= 1'b0;
      fault_o        <= 1'b0;
      fault_region_o <= '0;
    end else begin
      fault_valid_o <= accept_i;
      // Result holds until the next accepted transaction
      if (accept_i) begin
        fault_o        <= fault;
        fault_region_o <= match_idx_i;
      end
    end
  end

  always_comb begin
    inc                          = '0;
    inc[pma_pkg::CNT_ACCESS]     = accept_i;
    inc[pma_pkg::CNT_NOMATCH]    = accept_i && !have_match_i;
    inc[pma_pkg::CNT_MULTIMATCH] = accept_i && match_multi_i;
    inc[pma_pkg::CNT_FAULT]      = accept_i && fault;
    inc[pma_pkg::CNT_MISALIGNED] = accept_i && misaligned_i;
    inc[pma_pkg::CNT_LOAD]       = accept_i && (kind_i == pma_pkg::KIND_LOAD);
    inc[pma_pkg::CNT_STORE]      = accept_i && (kind_i == pma_pkg::KIND_STORE);
    inc[pma_pkg::CNT_EXEC]       = accept_i && is_exec;
  end

  // Clear wins over a same cycle increment
  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < pma_pkg::PMA_NUM_COUNTERS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < pma_pkg::PMA_NUM_COUNTERS; i++) begin
        if (cnt_clear_i) begin
          cnt_q[i] <= '0;
        end else if (inc[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign cnt_rdata_o = cnt_q[cnt_idx_i];

endmodule

`default_nettype wire

/* src/pma_monitor_top.sv */
/*
  PMA monitor top level: APB registers, region matcher,
  access classifier and fault and counter block
*/
`timescale 1ns/1ns
`default_nettype none

module pma_monitor_top (
  input  logic                              clk_ungated,
  input  logic                              rst_n,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [pma_pkg::APB_ADDR_W-1:0]    paddr_i,
  input  logic [31:0]                       pwdata_i,
  output logic [31:0]                       prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  input  logic                              trans_valid_i,
  input  logic                              trans_ready_i,
  input  logic [31:0]                       trans_addr_i,
  input  logic [1:0]                        trans_size_i,
  input  logic                              trans_write_i,
  input  logic                              trans_fetch_i,
  output logic                              fault_valid_o,
  output logic                              fault_o,
  output logic [pma_pkg::REGION_IDX_W-1:0]  fault_region_o
);

  logic [pma_pkg::PMA_NUM_REGIONS-1:0]  region_we;
  logic [pma_pkg::REGION_IDX_W-1:0]     region_idx;
  logic [1:0]                           region_sel;
  logic [31:0]                          wdata;
  logic [31:0]                          region_rdata;
  logic                                 cnt_clear;
  logic [pma_pkg::CNT_IDX_W-1:0]        cnt_idx;
  logic [pma_pkg::CNT_W-1:0]            cnt_rdata;
  logic                                 have_match;
  logic [pma_pkg::REGION_IDX_W-1:0]     match_idx;
  logic                                 match_multi;
  pma_pkg::pma_attr_u                   match_attr;
  logic                                 accept;
  logic [1:0]                           kind;
  logic                                 misaligned;

  pma_apb_regs pma_apb_regs_inst (
    .clk_ungated    (clk_ungated),
    .rst_n          (rst_n),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .region_we_o    (region_we),
    .region_idx_o   (region_idx),
    .region_sel_o   (region_sel),
    .wdata_o        (wdata),
    .cnt_clear_o    (cnt_clear),
    .cnt_rdata_i    (cnt_rdata),
    .cnt_idx_o      (cnt_idx),
    .region_rdata_i (region_rdata)
  );

  pma_region_match pma_region_match_inst (
    .clk_ungated    (clk_ungated),
    .rst_n          (rst_n),
    .region_we_i    (region_we),
    .region_idx_i   (region_idx),
    .region_sel_i   (region_sel),
    .wdata_i        (wdata),
    .region_rdata_o (region_rdata),
    .trans_addr_i   (trans_addr_i),
    .have_match_o   (have_match),
    .match_idx_o    (match_idx),
    .match_multi_o  (match_multi),
    .match_attr_o   (match_attr)
  );

  pma_access_classify pma_access_classify_inst (
    .trans_valid_i (trans_valid_i),
    .trans_ready_i (trans_ready_i),
    .trans_addr_i  (trans_addr_i[1:0]),
    .trans_size_i  (trans_size_i),
    .trans_write_i (trans_write_i),
    .trans_fetch_i (trans_fetch_i),
    .accept_o      (accept),
    .kind_o        (kind),
    .misaligned_o  (misaligned)
  );

  pma_fault_count pma_fault_count_inst (
    .clk_ungated    (clk_ungated),
    .rst_n          (rst_n),
    .accept_i       (accept),
    .kind_i         (kind),
    .misaligned_i   (misaligned),
    .have_match_i   (have_match),
    .match_idx_i    (match_idx),
    .match_multi_i  (match_multi),
    .match_attr_i   (match_attr),
    .cnt_clear_i    (cnt_clear),
    .cnt_idx_i      (cnt_idx),
    .cnt_rdata_o    (cnt_rdata),
    .fault_valid_o  (fault_valid_o),
    .fault_o        (fault_o),
    .fault_region_o (fault_region_o)
  );

endmodule

`default_nettype wire

/* src/pma_pkg.sv */
/*
  Shared sizes, APB address map, counter indices, access kind codes
  and the region attribute word for the PMA monitor
*/
`default_nettype none

package pma_pkg;

  localparam int PMA_NUM_REGIONS  = 4;
  localparam int PMA_NUM_COUNTERS = 8;
  localparam int CNT_W            = 16;
  localparam int REGION_IDX_W     = $clog2(PMA_NUM_REGIONS);
  localparam int CNT_IDX_W        = $clog2(PMA_NUM_COUNTERS);

  // APB address map, 12-bit byte address
  localparam int              APB_ADDR_W    = 12;
  localparam int              REGION_STRIDE = 16;
  localparam logic [11:0]     COUNTER_BASE  = 12'h100;

  // Register select within a region, equal to the byte offset divided by 4
  localparam logic [1:0] SEL_BASE = 2'd0;
  localparam logic [1:0] SEL_MASK = 2'd1;
  localparam logic [1:0] SEL_ATTR = 2'd2;

  // Event counter indices
  localparam int CNT_ACCESS     = 0;
  localparam int CNT_NOMATCH    = 1;
  localparam int CNT_MULTIMATCH = 2;
  localparam int CNT_FAULT      = 3;
  localparam int CNT_MISALIGNED = 4;
  localparam int CNT_LOAD       = 5;
  localparam int CNT_STORE      = 6;
  localparam int CNT_EXEC       = 7;

  // Access kind
  localparam logic [1:0] KIND_LOAD  = 2'd0;
  localparam logic [1:0] KIND_STORE = 2'd1;
  localparam logic [1:0] KIND_EXEC  = 2'd2;

  // Transaction size
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  typedef struct packed {
    logic [26:0] reserved;
    logic        integrity;
    logic        cacheable;
    logic        bufferable;
    logic        main;
    logic        allow;
  } pma_attr_fields_t;

  // Written as a raw APB word, decoded as attribute fields
  typedef union packed {
    logic [31:0]      raw;
    pma_attr_fields_t fields;
  } pma_attr_u;

endpackage

`default_nettype wire

/* src/pma_region_match.sv */
/*
  Region base, mask and attribute registers with readback,
  plus match list, first match and multiple match detection
*/
`timescale 1ns/1ns
`default_nettype none

module pma_region_match (
  input  logic                                 clk_ungated,
  input  logic                                 rst_n,
  input  logic [pma_pkg::PMA_NUM_REGIONS-1:0]  region_we_i,
  input  logic [pma_pkg::REGION_IDX_W-1:0]     region_idx_i,
  input  logic [1:0]                           region_sel_i,
  input  logic [31:0]                          wdata_i,
  output logic [31:0]                          region_rdata_o,
  input  logic [31:0]                          trans_addr_i,
  output logic                                 have_match_o,
  output logic [pma_pkg::REGION_IDX_W-1:0]     match_idx_o,
  output logic                                 match_multi_o,
  output pma_pkg::pma_attr_u                   match_attr_o
);

  localparam int NUM_W = $clog2(pma_pkg::PMA_NUM_REGIONS + 1);

  logic [31:0]                               base_q [pma_pkg::PMA_NUM_REGIONS];
  logic [31:0]                               mask_q [pma_pkg::PMA_NUM_REGIONS];
  pma_pkg::pma_attr_u                        attr_q [pma_pkg::PMA_NUM_REGIONS];
  pma_pkg::pma_attr_u                        attr_wr;
  logic [pma_pkg::PMA_NUM_REGIONS-1:0]       match_list;
  logic [NUM_W-1:0]                          match_num;

  // Reserved attribute bits never get stored
  always_comb begin
    attr_wr                 = wdata_i;
    attr_wr.fields.reserved = '0;
  end

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < pma_pkg::PMA_NUM_REGIONS; i++) begin
        base_q[i] <= '0;
        mask_q[i] <= '0;
        attr_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < pma_pkg::PMA_NUM_REGIONS; i++) begin
        if (region_we_i[i]) begin
          case (region_sel_i)
            pma_pkg::SEL_BASE: base_q[i] <= wdata_i;
            pma_pkg::SEL_MASK: mask_q[i] <= wdata_i;
            pma_pkg::SEL_ATTR: attr_q[i] <= attr_wr;
            default: ;
          endcase
        end
      end
    end
  end

  // APB readback
  always_comb begin
    case (region_sel_i)
      pma_pkg::SEL_BASE: region_rdata_o = base_q[region_idx_i];
      pma_pkg::SEL_MASK: region_rdata_o = mask_q[region_idx_i];
      pma_pkg::SEL_ATTR: region_rdata_o = attr_q[region_idx_i].raw;
      default:           region_rdata_o = '0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < pma_pkg::PMA_NUM_REGIONS; i++) begin
      match_list[i] = ((trans_addr_i & mask_q[i]) == (base_q[i] & mask_q[i]));
    end
  end

  // Walk down so the lowest matching index wins
  always_comb begin
    match_idx_o = '0;
    match_num   = '0;
    for (int i = pma_pkg::PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_list[i]) begin
        match_idx_o = pma_pkg::REGION_IDX_W'(i);
        match_num   = match_num + 1'b1;
      end
    end
  end

  assign have_match_o  = |match_list;
  assign match_multi_o = (match_num > 1);
  assign match_attr_o  = have_match_o ? attr_q[match_idx_o] : '0;

endmodule

`default_nettype wire

/* tb/pma_input_vectors.txt */
# W addr data | R addr exp_data exp_pslverr | T addr size write fetch ready exp_fault exp_region
# All fields hex, size 0 byte 1 half 2 word
# Region 0 main memory, region 3 overlaps it
W 000 80000000
W 004 F0000000
W 008 0000000B
W 010 10000000
W 014 FFFF0000
W 018 00000001
W 020 20000000
W 024 FFFF0000
W 028 00000002
W 030 80001000
W 034 FFFFF000
W 038 FFFFFFE3
# Readback, reserved attribute bits come back as zero
R 000 80000000 0
R 004 F0000000 0
R 028 00000002 0
R 038 00000003 0
# Unmapped addresses
R 00C 00000000 1
R 200 00000000 1
R 120 00000000 1
# Fault rule by attribute and matching
T 80000010 2 0 0 1 0 0
T 10000004 2 1 0 1 0 1
T 30000000 2 0 0 1 1 0
T 20000000 2 0 0 1 1 2
T 10000000 2 0 1 1 1 1
T 10000002 2 0 0 1 1 1
T 80000001 1 1 0 1 0 0
T 80001004 2 0 1 1 0 0
T 10000008 2 0 0 0 0 0
T 80000003 0 0 0 1 0 0
# Counters in index order
R 100 00000009 0
R 104 00000001 0
R 108 00000001 0
R 10C 00000004 0
R 110 00000002 0
R 114 00000005 0
R 118 00000002 0
R 11C 00000002 0
# Clear through any counter address, then count again
W 108 00000000
R 100 00000000 0
R 10C 00000000 0
T 80000000 2 1 0 1 0 0
T 40000000 2 0 0 1 1 0
R 100 00000002 0
R 10C 00000001 0
R 104 00000001 0
R 118 00000001 0

/* tb/pma_monitor_asserts.sv */
/*
  APB ready, result timing and known-output properties of the PMA monitor,
  bound to the top level
*/
`timescale 1ns/1ns
`default_nettype none

module pma_monitor_asserts (
  input logic        clk_ungated,
  input logic        rst_n,
  input logic        psel_i,
  input logic        penable_i,
  input logic        pready_i,
  input logic        pslverr_i,
  input logic [31:0] prdata_i,
  input logic        trans_valid_i,
  input logic        trans_ready_i,
  input logic        fault_valid_i,
  input logic        fault_i,
  input logic [1:0]  fault_region_i
);

  // Ready only in the second access cycle, after one setup and one wait cycle
  ready_in_access: assert property (@(posedge clk_ungated) disable iff (!rst_n)
    pready_i |-> (psel_i && penable_i && $past(psel_i && penable_i) &&
                  $past(psel_i && !penable_i, 2)))
    else $error("pready raised outside the second APB access cycle");

  // One result pulse per accepted transaction in the following cycle
  result_one_cycle: assert property (@(posedge clk_ungated) disable iff (!rst_n)
    fault_valid_i == $past(trans_valid_i && trans_ready_i))
    else $error("fault_valid does not follow acceptance by one cycle");

  outputs_known: assert property (@(posedge clk_ungated) disable iff (!rst_n)
    !$isunknown({prdata_i, pready_i, pslverr_i, fault_valid_i, fault_i, fault_region_i}))
    else $error("DUT output is unknown after reset");

endmodule

bind pma_monitor_top pma_monitor_asserts pma_monitor_asserts_inst (
  .clk_ungated    (clk_ungated),
  .rst_n          (rst_n),
  .psel_i         (psel_i),
  .penable_i      (penable_i),
  .pready_i       (pready_o),
  .pslverr_i      (pslverr_o),
  .prdata_i       (prdata_o),
  .trans_valid_i  (trans_valid_i),
  .trans_ready_i  (trans_ready_i),
  .fault_valid_i  (fault_valid_o),
  .fault_i        (fault_o),
  .fault_region_i (fault_region_o)
);

`default_nettype wire

/* tb/pma_monitor_tb.sv */
/*
  Testbench for the PMA monitor: clock, reset, file driven APB and bus stimulus,
  an event tally of its own, checks and a cycle limit
*/
`timescale 1ns/1ns
`default_nettype none

module pma_monitor_tb;

  logic        clk_ungated;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        trans_valid;
  logic        trans_ready;
  logic [31:0] trans_addr;
  logic [1:0]  trans_size;
  logic        trans_write;
  logic        trans_fetch;
  logic        fault_valid;
  logic        fault;
  logic [1:0]  fault_region;

  // Mirror of the region base and mask registers
  logic [31:0] base_m [pma_pkg::PMA_NUM_REGIONS];
  logic [31:0] mask_m [pma_pkg::PMA_NUM_REGIONS];
  int unsigned tally [pma_pkg::PMA_NUM_COUNTERS];

  int          cycle_cnt;
  int          cycle_limit;
  int          n_records;
  int          error_count;
  int          fd;
  int          rc;
  int          seed_val;
  logic [63:0] tag;
  logic [8*200-1:0] rest;
  logic [31:0] f_addr;
  logic [31:0] f_data;
  logic [31:0] f_exp;
  logic [31:0] f_err;
  logic [31:0] f_size;
  logic [31:0] f_write;
  logic [31:0] f_fetch;
  logic [31:0] f_ready;
  logic [31:0] f_fault;
  logic [31:0] f_region;
  logic [31:0] rdata;
  logic        err;

  pma_monitor_top pma_monitor_top_inst (
    .clk_ungated    (clk_ungated),
    .rst_n          (rst_n),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .paddr_i        (paddr),
    .pwdata_i       (pwdata),
    .prdata_o       (prdata),
    .pready_o       (pready),
    .pslverr_o      (pslverr),
    .trans_valid_i  (trans_valid),
    .trans_ready_i  (trans_ready),
    .trans_addr_i   (trans_addr),
    .trans_size_i   (trans_size),
    .trans_write_i  (trans_write),
    .trans_fetch_i  (trans_fetch),
    .fault_valid_o  (fault_valid),
    .fault_o        (fault),
    .fault_region_o (fault_region)
  );

  initial begin
    clk_ungated = 1'b0;
    forever #20 clk_ungated = ~clk_ungated;
  end

  always @(posedge clk_ungated) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("error: timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    error_count++;
    $display("error: %s expected %0h actual %0h", name, exp, act);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_fields(input int got, input int want, input string kind);
    if (got != want) begin
      $display("error: %s record in the vector file has %0d fields, %0d expected",
               kind, got, want);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  function automatic bit is_counter_addr(input logic [11:0] addr);
    return (addr >= pma_pkg::COUNTER_BASE) &&
           (addr < pma_pkg::COUNTER_BASE + 4 * pma_pkg::PMA_NUM_COUNTERS) &&
           (addr[1:0] == 2'b00);
  endfunction

  task automatic bump(input int idx);
    if (tally[idx] < 32'h0000_ffff) begin
      tally[idx]++;
    end
  endtask

  task automatic apb_access(input logic write, input logic [11:0] addr, input logic [31:0] data,
                            output logic [31:0] rd, output logic rerr);
    int waits;
    waits = 0;
    @(negedge clk_ungated);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk_ungated);
    penable = 1'b1;
    do begin
      @(negedge clk_ungated);
      waits++;
    end while (!pready);
    // One wait state, so ready comes in the second access cycle
    assert (waits == 1)
      else report_mismatch($sformatf("apb %03h ready delay", addr), 1, waits);
    rd   = prdata;
    rerr = pslverr;
    @(negedge clk_ungated);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Mirror region base and mask writes, and the counter clear
  task automatic note_apb_write(input logic [11:0] addr, input logic [31:0] data);
    if (addr < pma_pkg::PMA_NUM_REGIONS * pma_pkg::REGION_STRIDE && addr[1:0] == 2'b00) begin
      if (addr[3:2] == pma_pkg::SEL_BASE) begin
        base_m[addr[5:4]] = data;
      end else if (addr[3:2] == pma_pkg::SEL_MASK) begin
        mask_m[addr[5:4]] = data;
      end
    end else if (is_counter_addr(addr)) begin
      for (int k = 0; k < pma_pkg::PMA_NUM_COUNTERS; k++) begin
        tally[k] = 0;
      end
    end
  endtask

  task automatic drive_trans(input logic [31:0] addr, input logic [1:0] size,
                             input logic write, input logic fetch, input logic rdy);
    trans_valid = 1'b1;
    trans_ready = rdy;
    trans_addr  = addr;
    trans_size  = size;
    trans_write = write;
    trans_fetch = fetch;
  endtask

  task automatic run_transaction(input logic [31:0] addr, input logic [1:0] size,
                                 input logic write, input logic fetch, input logic rdy,
                                 input logic exp_fault, input logic [1:0] exp_region);
    int    nmatch;
    logic  mis;
    string name;
    name   = $sformatf("transaction %08h", addr);
    nmatch = 0;
    for (int r = 0; r < pma_pkg::PMA_NUM_REGIONS; r++) begin
      if ((addr & mask_m[r]) == (base_m[r] & mask_m[r])) begin
        nmatch++;
      end
    end
    if (size == pma_pkg::SIZE_BYTE) begin
      mis = 1'b0;
    end else if (size == pma_pkg::SIZE_HALF) begin
      mis = addr[0];
    end else begin
      mis = (addr[1:0] != 2'b00);
    end
    // Back-pressure cycle ahead of some accepted transactions
    if (rdy && ($urandom % 3 == 0)) begin
      @(negedge clk_ungated);
      drive_trans(addr, size, write, fetch, 1'b0);
    end
    @(negedge clk_ungated);
    drive_trans(addr, size, write, fetch, rdy);
    @(negedge clk_ungated);
    trans_valid = 1'b0;
    trans_ready = 1'b0;
    if (!rdy) begin
      assert (fault_valid == 1'b0)
        else report_mismatch({name, " result without acceptance"}, 0, fault_valid);
    end else begin
      while (!fault_valid) begin
        @(negedge clk_ungated);
      end
      assert (fault == exp_fault) else report_mismatch({name, " fault"}, exp_fault, fault);
      if (nmatch > 0) begin
        assert (fault_region == exp_region)
          else report_mismatch({name, " region"}, exp_region, fault_region);
      end
      bump(pma_pkg::CNT_ACCESS);
      if (nmatch == 0) begin
        bump(pma_pkg::CNT_NOMATCH);
      end
      if (nmatch > 1) begin
        bump(pma_pkg::CNT_MULTIMATCH);
      end
      if (exp_fault) begin
        bump(pma_pkg::CNT_FAULT);
      end
      if (mis) begin
        bump(pma_pkg::CNT_MISALIGNED);
      end
      if (fetch) begin
        bump(pma_pkg::CNT_EXEC);
      end else if (write) begin
        bump(pma_pkg::CNT_STORE);
      end else begin
        bump(pma_pkg::CNT_LOAD);
      end
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    trans_valid = 1'b0;
    trans_ready = 1'b0;
    trans_addr  = '0;
    trans_size  = '0;
    trans_write = 1'b0;
    trans_fetch = 1'b0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    n_records   = 0;
    error_count = 0;
    seed_val    = $urandom(99515);
    for (int r = 0; r < pma_pkg::PMA_NUM_REGIONS; r++) begin
      base_m[r] = '0;
      mask_m[r] = '0;
    end
    for (int k = 0; k < pma_pkg::PMA_NUM_COUNTERS; k++) begin
      tally[k] = 0;
    end

    // First pass counts records to size the cycle limit
    fd = $fopen("tb/pma_input_vectors.txt", "r");
    if (fd == 0) begin
      $display("error: the vector file tb/pma_input_vectors.txt could not be opened");
      $display("Test failed");
      $fatal(1);
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag != "#") begin
        n_records++;
      end
      rc = $fgets(rest, fd);
    end
    $fclose(fd);
    cycle_limit = n_records * 4 + 20;

    repeat (4) @(negedge clk_ungated);
    rst_n = 1'b1;

    fd = $fopen("tb/pma_input_vectors.txt", "r");
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "W") begin
        rc = $fscanf(fd, "%h %h", f_addr, f_data);
        check_fields(rc, 2, "APB write");
        apb_access(1'b1, f_addr[11:0], f_data, rdata, err);
        note_apb_write(f_addr[11:0], f_data);
      end else if (tag == "R") begin
        rc = $fscanf(fd, "%h %h %h", f_addr, f_exp, f_err);
        check_fields(rc, 3, "APB read");
        apb_access(1'b0, f_addr[11:0], '0, rdata, err);
        assert (err == f_err[0])
          else report_mismatch($sformatf("apb read %03h pslverr", f_addr[11:0]), f_err, err);
        assert (rdata == f_exp)
          else report_mismatch($sformatf("apb read %03h data", f_addr[11:0]), f_exp, rdata);
        if (is_counter_addr(f_addr[11:0])) begin
          assert (rdata == tally[(f_addr[11:0] - pma_pkg::COUNTER_BASE) >> 2])
            else report_mismatch($sformatf("counter read %03h tally", f_addr[11:0]),
                                 tally[(f_addr[11:0] - pma_pkg::COUNTER_BASE) >> 2], rdata);
        end
      end else if (tag == "T") begin
        rc = $fscanf(fd, "%h %h %h %h %h %h %h", f_addr, f_size, f_write, f_fetch,
                     f_ready, f_fault, f_region);
        check_fields(rc, 7, "transaction");
        run_transaction(f_addr, f_size[1:0], f_write[0], f_fetch[0], f_ready[0],
                        f_fault[0], f_region[1:0]);
      end
      rc = $fgets(rest, fd);
    end
    $fclose(fd);

    repeat (2) @(negedge clk_ungated);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
